//--- hdl/capture_buf.sv
`timescale 1ns/1ps

module capture_buf (
    input  logic                       clk_60MHz,
    input  logic                       rst_n,
    input  logic                       xcorr_start,
    input  logic                       engine_busy,
    input  mic_pkg::mic_pair_t         pair,
    input  logic                       pair_valid,
    input  logic [mic_pkg::ADDR_W-1:0] addr_x,
    input  logic [mic_pkg::ADDR_W-1:0] addr_y,
    output mic_pkg::sample_t           data_x,
    output mic_pkg::sample_t           data_y,
    output logic                       win_ready
);
    import mic_pkg::*;

    mic_pair_t         mem [WINDOW];         // one window of frames
    logic [ADDR_W-1:0] wr_cnt;
    logic              capturing;
    logic              start_ok;
    logic              wr_en;

    // a start is only taken when nothing else owns the buffer
    assign start_ok = xcorr_start & ~capturing & ~engine_busy & ~win_ready;
    assign wr_en    = capturing & pair_valid;

    ////////////////////////////////////////////////////////////////////////////
    // capture control
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_60MHz or negedge rst_n) begin
        if (!rst_n) begin
            capturing <= 1'b0;
            wr_cnt    <= '0;
            win_ready <= 1'b0;
        end else begin
            win_ready <= 1'b0;
            if (start_ok) begin
                capturing <= 1'b1;
                wr_cnt    <= '0;
            end else if (wr_en) begin
                wr_cnt <= wr_cnt + 1'b1;     // wraps to 0 after the last slot
                if (wr_cnt == ADDR_W'(WINDOW - 1)) begin
                    capturing <= 1'b0;       // hold until next accepted start
                    win_ready <= 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // storage and read ports
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_60MHz) begin
        if (wr_en)
            mem[wr_cnt] <= pair;
        data_x <= mem[addr_x].mic0;          // one clk read latency
        data_y <= mem[addr_y].mic1;
    end

    a_ready_idle : assert property (@(posedge clk_60MHz) disable iff (!rst_n)
        win_ready |-> !engine_busy);

endmodule

//--- hdl/i2s_rx.sv
`timescale 1ns/1ps

module i2s_rx (
    input  logic             clk_60MHz,
    input  logic             rst_n,
    input  logic             sck,
    input  logic             ws,
    input  logic             sd,
    output mic_pkg::sample_t sample,
    output logic             sample_valid
);
    import mic_pkg::*;

    localparam int CNT_W = $clog2(I2S_SLOT_W);

    logic [2:0]          sck_sync;           // two sync flops plus edge tap
    logic [1:0]          ws_sync;
    logic [1:0]          sd_sync;
    logic                sck_rise;
    logic                ws_prev;            // ws seen at previous sck rise
    logic                collecting;         // inside the kept part of left slot
    logic [CNT_W-1:0]    bit_cnt;
    logic                word_done;
    logic [SAMPLE_W-1:0] shift_reg;

    assign sck_rise = sck_sync[1] & ~sck_sync[2];

    always_ff @(posedge clk_60MHz or negedge rst_n) begin
        if (!rst_n) begin
            sck_sync     <= '0;
            ws_sync      <= '0;
            sd_sync      <= '0;
            ws_prev      <= 1'b0;            // no false slot start out of reset
            collecting   <= 1'b0;
            bit_cnt      <= '0;
            word_done    <= 1'b0;
            sample_valid <= 1'b0;
        end else begin
            sck_sync     <= {sck_sync[1:0], sck};
            ws_sync      <= {ws_sync[0], ws};
            sd_sync      <= {sd_sync[0], sd};
            word_done    <= 1'b0;
            sample_valid <= word_done;       // strobe with the published word
            if (sck_rise) begin
                ws_prev <= ws_sync[1];
                if (ws_prev && !ws_sync[1]) begin
                    collecting <= 1'b1;      // msb comes on the next sck
                    bit_cnt    <= '0;
                end else if (collecting) begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == CNT_W'(SAMPLE_W - 1)) begin
                        collecting <= 1'b0;  // rest of the slot dropped
                        word_done  <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_60MHz) begin
        if (sck_rise && collecting && !(ws_prev && !ws_sync[1]))
            shift_reg <= {shift_reg[SAMPLE_W-2:0], sd_sync[1]};  // msb first
        if (word_done)
            sample <= shift_reg;
    end

    a_slot_after_word : assert property (@(posedge clk_60MHz) disable iff (!rst_n)
        (sck_rise && ws_prev && !ws_sync[1]) |-> !collecting);

endmodule

//--- hdl/mic_pkg.sv
package mic_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // audio and serial framing
    ////////////////////////////////////////////////////////////////////////////
    localparam int SAMPLE_W   = 16;          // kept bits per left word
    localparam int I2S_SLOT_W = 32;          // sck per channel slot

    ////////////////////////////////////////////////////////////////////////////
    // correlation window and lag search
    ////////////////////////////////////////////////////////////////////////////
    localparam int WINDOW     = 64;          // sample pairs per capture
    localparam int ADDR_W     = 6;           // log2 of WINDOW
    localparam int LAG_MAX    = 10;          // sweep covers -LAG_MAX..+LAG_MAX
    localparam int LAG_W      = 6;           // signed lag width
    localparam int ACC_W      = 32;          // signed correlation sum

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // both mics from one frame
    typedef struct packed {
        sample_t mic0;                       // upper half
        sample_t mic1;                       // lower half
    } mic_pair_t;

    // one correlation point
    typedef struct packed {
        logic signed [LAG_W-1:0] lag;        // lag of this sum
        logic signed [ACC_W-1:0] value;      // raw signed sum
    } xcorr_res_t;

endpackage

//--- hdl/mic_subsys.sv
`timescale 1ns/1ps

module mic_subsys (
    input  logic                             clk_60MHz,
    input  logic                             rst_n,
    input  logic                             mic_sck,
    input  logic                             mic_ws,
    input  logic                             mic0_sd,
    input  logic                             mic1_sd,
    input  logic                             xcorr_start,
    output logic signed [mic_pkg::LAG_W-1:0] lag_diff,
    output logic                             lag_valid
);
    import mic_pkg::*;

    sample_t           mic0_sample;
    sample_t           mic1_sample;
    logic              mic0_valid;
    mic_pair_t         pair;
    logic [ADDR_W-1:0] addr_x;
    logic [ADDR_W-1:0] addr_y;
    sample_t           data_x;
    sample_t           data_y;
    logic              win_ready;
    logic              busy;
    xcorr_res_t        res;
    logic              res_valid;
    logic              res_last;

    assign pair = '{mic0: mic0_sample, mic1: mic1_sample};  // same frame on both

    ////////////////////////////////////////////////////////////////////////////
    // receivers share sck and ws
    ////////////////////////////////////////////////////////////////////////////
    i2s_rx i2s_rx_mic0 (
        .clk_60MHz    (clk_60MHz),
        .rst_n        (rst_n),
        .sck          (mic_sck),
        .ws           (mic_ws),
        .sd           (mic0_sd),
        .sample       (mic0_sample),
        .sample_valid (mic0_valid)
    );

    i2s_rx i2s_rx_mic1 (
        .clk_60MHz    (clk_60MHz),
        .rst_n        (rst_n),
        .sck          (mic_sck),
        .ws           (mic_ws),
        .sd           (mic1_sd),
        .sample       (mic1_sample),
        .sample_valid ()
    );

    ////////////////////////////////////////////////////////////////////////////
    // window buffer, correlator, peak search
    ////////////////////////////////////////////////////////////////////////////
    capture_buf capture_buf_i (
        .clk_60MHz   (clk_60MHz),
        .rst_n       (rst_n),
        .xcorr_start (xcorr_start),
        .engine_busy (busy),
        .pair        (pair),
        .pair_valid  (mic0_valid),           // mic1 strobes in the same cycle
        .addr_x      (addr_x),
        .addr_y      (addr_y),
        .data_x      (data_x),
        .data_y      (data_y),
        .win_ready   (win_ready)
    );

    xcorr_engine xcorr_engine_i (
        .clk_60MHz (clk_60MHz),
        .rst_n     (rst_n),
        .win_ready (win_ready),
        .addr_x    (addr_x),
        .addr_y    (addr_y),
        .data_x    (data_x),
        .data_y    (data_y),
        .res       (res),
        .res_valid (res_valid),
        .res_last  (res_last),
        .busy      (busy)
    );

    peak_lag peak_lag_i (
        .clk_60MHz (clk_60MHz),
        .rst_n     (rst_n),
        .res       (res),
        .res_valid (res_valid),
        .res_last  (res_last),
        .lag_diff  (lag_diff),
        .lag_valid (lag_valid)
    );

endmodule

//--- hdl/peak_lag.sv
`timescale 1ns/1ps

module peak_lag (
    input  logic                             clk_60MHz,
    input  logic                             rst_n,
    input  mic_pkg::xcorr_res_t              res,
    input  logic                             res_valid,
    input  logic                             res_last,
    output logic signed [mic_pkg::LAG_W-1:0] lag_diff,
    output logic                             lag_valid
);
    import mic_pkg::*;

    logic [ACC_W-1:0]        abs_val;
    logic [ACC_W-1:0]        max_val;        // running peak magnitude
    logic signed [LAG_W-1:0] cand_lag;       // lag of running peak
    logic signed [LAG_W-1:0] win_lag;
    logic                    restart;
    logic                    take_new;

    assign abs_val  = res.value[ACC_W-1] ? -res.value : res.value;
    assign restart  = (res.lag == -LAG_MAX);              // first lag of a sweep
    assign take_new = restart || (abs_val >= max_val);    // ties go to later lag
    assign win_lag  = take_new ? res.lag : cand_lag;

    always_ff @(posedge clk_60MHz or negedge rst_n) begin
        if (!rst_n) begin
            max_val   <= '0;
            cand_lag  <= '0;
            lag_diff  <= '0;
            lag_valid <= 1'b0;
        end else begin
            lag_valid <= res_valid & res_last;
            if (res_valid) begin
                if (take_new) begin
                    max_val  <= abs_val;
                    cand_lag <= res.lag;
                end
                if (res_last)
                    lag_diff <= win_lag;     // held until next sweep ends
            end
        end
    end

    a_last_is_top_lag : assert property (@(posedge clk_60MHz) disable iff (!rst_n)
        (res_valid && res_last) |-> (res.lag == LAG_MAX));

endmodule

//--- hdl/xcorr_engine.sv
`timescale 1ns/1ps

module xcorr_engine (
    input  logic                       clk_60MHz,
    input  logic                       rst_n,
    input  logic                       win_ready,
    output logic [mic_pkg::ADDR_W-1:0] addr_x,
    output logic [mic_pkg::ADDR_W-1:0] addr_y,
    input  mic_pkg::sample_t           data_x,
    input  mic_pkg::sample_t           data_y,
    output mic_pkg::xcorr_res_t        res,
    output logic                       res_valid,
    output logic                       res_last,
    output logic                       busy
);
    import mic_pkg::*;

    localparam int IDX_W    = ADDR_W + 1;    // counts past the window
    localparam int LAST_IDX = WINDOW + 2;    // WINDOW+3 clk per lag

    logic                    issuing;        // counters running
    logic [IDX_W-1:0]        idx;            // n within the lag
    logic signed [LAG_W-1:0] lag;
    logic signed [IDX_W:0]   pos_y;          // n+L which may leave the window
    logic                    issue;
    logic                    in_win;
    logic                    v1;             // read valid
    logic                    l1;             // last n of lag at data stage
    logic                    l2;             // last n of lag at product stage
    logic signed [LAG_W-1:0] lag1;
    logic signed [LAG_W-1:0] lag2;
    logic signed [ACC_W-1:0] prod;
    logic signed [ACC_W-1:0] acc;

    assign pos_y  = $signed({1'b0, idx}) + lag;
    assign issue  = issuing && (idx < WINDOW);
    assign in_win = (pos_y >= 0) && (pos_y < WINDOW);
    assign addr_x = idx[ADDR_W-1:0];
    assign addr_y = pos_y[ADDR_W-1:0];       // masked later when out of range

    ////////////////////////////////////////////////////////////////////////////
    // lag and index sequencing
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_60MHz or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            issuing <= 1'b0;
            idx     <= '0;
            lag     <= '0;
        end else begin
            if (win_ready && !busy) begin
                busy    <= 1'b1;
                issuing <= 1'b1;
                idx     <= '0;
                lag     <= LAG_W'(-LAG_MAX);
            end else if (issuing) begin
                if (idx == IDX_W'(LAST_IDX)) begin
                    idx <= '0;
                    if (lag == LAG_MAX)
                        issuing <= 1'b0;     // last lag issued
                    else
                        lag <= lag + 1'b1;
                end else begin
                    idx <= idx + 1'b1;
                end
            end
            if (res_valid && res_last)
                busy <= 1'b0;                // sweep fully flushed
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read, multiply, accumulate
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_60MHz or negedge rst_n) begin
        if (!rst_n) begin
            v1        <= 1'b0;
            l1        <= 1'b0;
            l2        <= 1'b0;
            prod      <= '0;
            acc       <= '0;
            res_valid <= 1'b0;
            res_last  <= 1'b0;
        end else begin
            v1 <= issue && in_win;           // travels with the read
            l1 <= issue && (idx == WINDOW - 1);
            l2 <= l1;
            if (v1)
                prod <= data_x * data_y;
            else
                prod <= '0;                  // out of window or idle
            acc       <= l2 ? '0 : acc + prod;
            res_valid <= l2;
            res_last  <= l2 && (lag2 == LAG_MAX);
        end
    end

    always_ff @(posedge clk_60MHz) begin
        lag1 <= lag;
        lag2 <= lag1;                        // aligned with prod
        if (l2) begin
            res.lag   <= lag2;
            res.value <= acc + prod;         // includes the final product
        end
    end

    a_result_in_sweep : assert property (@(posedge clk_60MHz) disable iff (!rst_n)
        res_valid |-> busy);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, pass only if the log says so
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module mic_subsys_tb \
    --Mdir obj_dir -o mic_subsys_tb > build.log 2>&1 \
    && ./obj_dir/mic_subsys_tb > sim.log 2>&1 \
    && grep -q "^SIMULATION PASSED$" sim.log \
    && { echo "run passed, see sim.log"; exit 0; } \
    || { echo "run failed, see build.log and sim.log"; exit 1; }

//--- tb/i2s_mic_model.sv
`timescale 1ns/1ps

module i2s_mic_model (
    input  logic             clk_60MHz,
    input  logic             rst_n,
    input  mic_pkg::sample_t mic0_word,      // word for the frame about to start
    input  mic_pkg::sample_t mic1_word,
    output int               frame_idx,      // index of the next frame to latch
    output logic             sck,
    output logic             ws,
    output logic             sd0,
    output logic             sd1
);
    import mic_pkg::*;

    logic [2:0] div_cnt;                     // 8 clk per sck
    logic [5:0] bit_cnt;                     // sck position within the frame
    logic [5:0] next_bit;
    sample_t    sh0;                         // msb-first shifters
    sample_t    sh1;

    assign next_bit = bit_cnt + 6'd1;        // wraps at 64 sck per frame

    always @(negedge clk_60MHz or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt   <= '0;
            bit_cnt   <= 6'd63;              // first fall opens the left slot
            sck       <= 1'b0;
            ws        <= 1'b1;
            sd0       <= 1'b0;
            sd1       <= 1'b0;
            sh0       <= '0;
            sh1       <= '0;
            frame_idx <= 0;
        end else begin
            div_cnt <= div_cnt + 3'd1;
            if (div_cnt == 3'd3)
                sck <= 1'b1;
            if (div_cnt == 3'd7) begin
                sck     <= 1'b0;             // ws and data move on falling sck
                bit_cnt <= next_bit;
                ws      <= next_bit[5];      // low for the left slot
                if (next_bit == 6'd0) begin
                    sh0       <= mic0_word;  // msb goes out one sck after ws falls
                    sh1       <= mic1_word;
                    frame_idx <= frame_idx + 1;
                    sd0       <= 1'b0;
                    sd1       <= 1'b0;
                end else if (next_bit <= 6'(SAMPLE_W)) begin
                    sd0 <= sh0[SAMPLE_W-1];
                    sd1 <= sh1[SAMPLE_W-1];
                    sh0 <= {sh0[SAMPLE_W-2:0], 1'b0};
                    sh1 <= {sh1[SAMPLE_W-2:0], 1'b0};
                end else begin
                    sd0 <= 1'b0;             // unused bits and right slot
                    sd1 <= 1'b0;
                end
            end
        end
    end

endmodule

//--- tb/mic_subsys_tb.sv
`timescale 1ns/1ps

module mic_subsys_tb;
    import mic_pkg::*;

    localparam int SCK_DIV   = 8;                           // clk per sck
    localparam int FRAME_CLK = 2 * I2S_SLOT_W * SCK_DIV;    // one stereo frame
    localparam int SWEEP_CLK = (2 * LAG_MAX + 1) * (WINDOW + 3);
    localparam int TEST_CLK  = (WINDOW + 2) * FRAME_CLK + SWEEP_CLK;
    localparam int NUM_TESTS = 6;
    localparam int CLK_NS    = 100;

    logic                    clk_60MHz = 1'b0;
    logic                    rst_n;
    logic                    xcorr_start;
    logic                    mic_sck;
    logic                    mic_ws;
    logic                    mic0_sd;
    logic                    mic1_sd;
    logic signed [LAG_W-1:0] lag_diff;
    logic                    lag_valid;
    sample_t                 mic0_word;
    sample_t                 mic1_word;
    int                      frame_idx;
    sample_t                 seq [1024];     // periodic source sequence
    logic [9:0]              idx0;
    logic [9:0]              idx1;
    integer                  seed = 32'hfa44_57e5;
    int                      dly = 0;        // D, mic1 lags mic0 by this many frames
    int                      pol = 1;        // P, +1 or -1
    logic signed [LAG_W-1:0] exp_lag = '0;
    string                   test_name = "reset_idle";
    logic                    started = 1'b0;
    int                      expected_valids = 0;
    int                      seen_valids = 0;
    int                      value_errors = 0;
    int                      protocol_errors = 0;

    always #50 clk_60MHz = ~clk_60MHz;

    // mic1[n] = P * mic0[n-D], index wraps mod 1024
    assign idx0      = 10'(frame_idx);
    assign idx1      = 10'(frame_idx - dly);
    assign mic0_word = seq[idx0];
    assign mic1_word = sample_t'(pol * seq[idx1]);

    mic_subsys mic_subsys_i (
        .clk_60MHz   (clk_60MHz),
        .rst_n       (rst_n),
        .mic_sck     (mic_sck),
        .mic_ws      (mic_ws),
        .mic0_sd     (mic0_sd),
        .mic1_sd     (mic1_sd),
        .xcorr_start (xcorr_start),
        .lag_diff    (lag_diff),
        .lag_valid   (lag_valid)
    );

    i2s_mic_model mic_model_i (
        .clk_60MHz (clk_60MHz),
        .rst_n     (rst_n),
        .mic0_word (mic0_word),
        .mic1_word (mic1_word),
        .frame_idx (frame_idx),
        .sck       (mic_sck),
        .ws        (mic_ws),
        .sd0       (mic0_sd),
        .sd1       (mic1_sd)
    );

    always @(posedge clk_60MHz)
        if (lag_valid)
            seen_valids <= seen_valids + 1;

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////
    a_idle_zero : assert property (@(posedge clk_60MHz) disable iff (!rst_n)
        !started |-> (lag_diff == '0))
        else begin
            value_errors++;
            $display("ERROR %s: expected lag 0, actual lag %0d", test_name, lag_diff);
        end

    a_one_result : assert property (@(posedge clk_60MHz) disable iff (!rst_n)
        lag_valid |-> (seen_valids < expected_valids))
        else begin
            protocol_errors++;
            $display("%s: lag_valid pulsed with no accepted start pending", test_name);
        end

    a_lag_value : assert property (@(posedge clk_60MHz) disable iff (!rst_n)
        lag_valid |-> (lag_diff == exp_lag))
        else begin
            value_errors++;
            $display("ERROR %s: expected lag %0d, actual lag %0d",
                     test_name, exp_lag, lag_diff);
        end

    a_lag_held : assert property (@(posedge clk_60MHz) disable iff (!rst_n)
        !lag_valid |-> $stable(lag_diff))
        else begin
            protocol_errors++;
            $display("%s: lag_diff changed without lag_valid", test_name);
        end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////
    task automatic set_delay(input string name, input int d, input int p);
        @(negedge clk_60MHz);
        test_name = name;
        dly       = d;
        pol       = p;
        exp_lag   = LAG_W'(d);
        repeat (2 * FRAME_CLK) @(negedge clk_60MHz);    // flush frames latched earlier
    endtask

    task automatic pulse_start(input logic counted);
        @(negedge clk_60MHz);
        xcorr_start = 1'b1;
        started     = 1'b1;
        if (counted)
            expected_valids++;                          // this one should be taken
        @(negedge clk_60MHz);
        xcorr_start = 1'b0;
    endtask

    task automatic wait_result();
        while (seen_valids < expected_valids)
            @(negedge clk_60MHz);                       // watchdog bounds this
    endtask

    task automatic run_delay_test(input string name, input int d, input int p);
        set_delay(name, d, p);
        pulse_start(1'b1);
        wait_result();
    endtask

    initial begin
        rst_n       = 1'b0;
        xcorr_start = 1'b0;
        for (int i = 0; i < 1024; i++)
            seq[i] = sample_t'($random(seed) % 2048);  // within +-2047
        repeat (10) @(negedge clk_60MHz);
        rst_n = 1'b1;
        repeat (4 * FRAME_CLK) @(negedge clk_60MHz);   // idle, no start yet

        run_delay_test("delay_pos3", 3, 1);
        run_delay_test("delay_neg5", -5, 1);
        run_delay_test("delay_zero", 0, 1);
        run_delay_test("inverted_pos2", 2, -1);
        run_delay_test("edge_pos10", 10, 1);
        run_delay_test("edge_neg10", -10, 1);

        // extra starts, one while filling and one inside the sweep
        set_delay("extra_starts", 7, 1);
        pulse_start(1'b1);
        repeat (30 * FRAME_CLK) @(negedge clk_60MHz);
        pulse_start(1'b0);
        repeat (34 * FRAME_CLK + 100) @(negedge clk_60MHz);
        pulse_start(1'b0);
        wait_result();
        repeat (TEST_CLK) @(negedge clk_60MHz);        // room for a stray lag_valid

        $display("run done: %0d value errors, %0d protocol errors",
                 value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(NUM_TESTS * 2 * TEST_CLK * CLK_NS);
        $display("timeout: %s still waiting for lag_valid", test_name);
        $display("run stopped: %0d value errors, %0d protocol errors",
                 value_errors, protocol_errors);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- vlog.f
hdl/mic_pkg.sv
hdl/i2s_rx.sv
hdl/capture_buf.sv
hdl/xcorr_engine.sv
hdl/peak_lag.sv
hdl/mic_subsys.sv
tb/i2s_mic_model.sv
tb/mic_subsys_tb.sv
